// ==== design/trace_monitor_pkg.sv ====
/*
 * shared widths, APB register map, RISC-V constants and the trace packet
 * layout of the trace monitor; every file refers to these by scoped name
 */
`default_nettype none

package trace_monitor_pkg;

    // core side widths
    parameter int xlen            = 32;
    parameter int instr_width     = 32;
    parameter int num_events      = 4;
    parameter int event_cnt_width = 8;
    parameter int delta_width     = 32;
    parameter int pkt_width       = instr_width + xlen + delta_width
                                    + num_events * event_cnt_width;

    // APB slave bus
    parameter int apb_addr_width = 8;
    parameter int apb_data_width = 32;

    // register byte offsets
    // ctrl bits: 0 start trig en, 1 end trig en, 2 lower bound en, 3 upper bound en
    parameter logic [apb_addr_width-1:0] reg_ctrl           = 8'h00;
    parameter logic [apb_addr_width-1:0] reg_start_addr     = 8'h04;
    parameter logic [apb_addr_width-1:0] reg_end_addr       = 8'h08;
    parameter logic [apb_addr_width-1:0] reg_lower_bound    = 8'h0C;
    parameter logic [apb_addr_width-1:0] reg_upper_bound    = 8'h10;
    parameter logic [apb_addr_width-1:0] reg_tlast_interval = 8'h14;
    // status bits: 0 overflow (w1c), 1 start reached, 2 end reached
    parameter logic [apb_addr_width-1:0] reg_status         = 8'h18;

    // addi x0, x0, 0
    parameter logic [instr_width-1:0] nop_instr = 32'h0000_0013;

    // packet is built field by field and streamed out as one flat word
    typedef union packed {
        struct packed {
            logic [instr_width-1:0]                     instr;
            logic [xlen-1:0]                            pc;
            logic [delta_width-1:0]                     delta;
            logic [num_events-1:0][event_cnt_width-1:0] counts;
        } fields;
        logic [pkt_width-1:0] raw;
    } trace_pkt_u;

endpackage

`default_nettype wire

// ==== design/trace_ctrl_regs.sv ====
/*
 * APB slave with the trigger, address window and tlast interval registers,
 * plus status readback; zero wait states, unmapped offsets answer pslverr
 */
`timescale 1ns/1ps
`default_nettype none

module trace_ctrl_regs (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      psel,
    input  logic                                      penable,
    input  logic                                      pwrite,
    input  logic [trace_monitor_pkg::apb_addr_width-1:0] paddr,
    input  logic [trace_monitor_pkg::apb_data_width-1:0] pwdata,
    output logic [trace_monitor_pkg::apb_data_width-1:0] prdata,
    output logic                                      pready,
    output logic                                      pslverr,
    input  logic                                      start_reached,
    input  logic                                      end_reached,
    input  logic                                      overflow,
    output logic                                      start_en,
    output logic                                      end_en,
    output logic                                      lower_en,
    output logic                                      upper_en,
    output logic [trace_monitor_pkg::xlen-1:0]        start_addr,
    output logic [trace_monitor_pkg::xlen-1:0]        end_addr,
    output logic [trace_monitor_pkg::xlen-1:0]        lower_bound,
    output logic [trace_monitor_pkg::xlen-1:0]        upper_bound,
    output logic [trace_monitor_pkg::apb_data_width-1:0] tlast_interval,
    output logic                                      overflow_clr,
    output logic                                      trig_clr
);

    logic access;
    logic mapped;
    logic wr_en;

    // access phase, never stalled
    assign access  = psel & penable;
    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;
    assign wr_en   = access & pwrite & mapped;

    // pulses are live during the access phase, so they act on the same edge
    assign trig_clr     = wr_en & (paddr == trace_monitor_pkg::reg_ctrl);
    assign overflow_clr = wr_en & (paddr == trace_monitor_pkg::reg_status) & pwdata[0];

    // address decode and read mux
    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            trace_monitor_pkg::reg_ctrl:
                prdata[3:0] = {upper_en, lower_en, end_en, start_en};
            trace_monitor_pkg::reg_start_addr:     prdata = start_addr;
            trace_monitor_pkg::reg_end_addr:       prdata = end_addr;
            trace_monitor_pkg::reg_lower_bound:    prdata = lower_bound;
            trace_monitor_pkg::reg_upper_bound:    prdata = upper_bound;
            trace_monitor_pkg::reg_tlast_interval: prdata = tlast_interval;
            trace_monitor_pkg::reg_status:
                prdata[2:0] = {end_reached, start_reached, overflow};
            default: mapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_en       <= 1'b0;
            end_en         <= 1'b0;
            lower_en       <= 1'b0;
            upper_en       <= 1'b0;
            start_addr     <= '0;
            end_addr       <= '0;
            lower_bound    <= '0;
            upper_bound    <= '1;
            tlast_interval <= 32'd1;
        end else if (wr_en) begin
            case (paddr)
                trace_monitor_pkg::reg_ctrl: begin
                    start_en <= pwdata[0];
                    end_en   <= pwdata[1];
                    lower_en <= pwdata[2];
                    upper_en <= pwdata[3];
                end
                trace_monitor_pkg::reg_start_addr:     start_addr     <= pwdata;
                trace_monitor_pkg::reg_end_addr:       end_addr       <= pwdata;
                trace_monitor_pkg::reg_lower_bound:    lower_bound    <= pwdata;
                trace_monitor_pkg::reg_upper_bound:    upper_bound    <= pwdata;
                trace_monitor_pkg::reg_tlast_interval: tlast_interval <= pwdata;
                // status only has the w1c bit, handled by overflow_clr
                default: ;
            endcase
        end
    end

    // a setup phase moves straight into its access phase with the same address
    a_apb_setup_to_access: assert property (
        @(posedge clk) disable iff (!rst_n)
        (psel && !penable) |=> (psel && penable && $stable(paddr) && $stable(pwrite))
    );

endmodule

`default_nettype wire

// ==== design/trace_qualifier.sv ====
/*
 * two-stage pc/instr pipeline that spots newly arrived instructions and
 * gates them through the start/end triggers and the address window
 */
`timescale 1ns/1ps
`default_nettype none

module trace_qualifier (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [trace_monitor_pkg::xlen-1:0]        pc,
    input  logic [trace_monitor_pkg::instr_width-1:0] instr,
    input  logic                                     en,
    input  logic                                     start_en,
    input  logic                                     end_en,
    input  logic                                     lower_en,
    input  logic                                     upper_en,
    input  logic [trace_monitor_pkg::xlen-1:0]        start_addr,
    input  logic [trace_monitor_pkg::xlen-1:0]        end_addr,
    input  logic [trace_monitor_pkg::xlen-1:0]        lower_bound,
    input  logic [trace_monitor_pkg::xlen-1:0]        upper_bound,
    input  logic                                     trig_clr,
    output logic                                     capture,
    output logic [trace_monitor_pkg::xlen-1:0]        cap_pc,
    output logic [trace_monitor_pkg::instr_width-1:0] cap_instr,
    output logic                                     start_reached,
    output logic                                     end_reached
);

    logic [trace_monitor_pkg::xlen-1:0]        pc_s0;
    logic [trace_monitor_pkg::xlen-1:0]        pc_s1;
    logic [trace_monitor_pkg::instr_width-1:0] instr_s0;
    logic [trace_monitor_pkg::instr_width-1:0] instr_s1;
    logic                                     is_new;
    logic                                     trig_ok;
    logic                                     in_window;

    // pipeline, filled with pc 0 / nop so nothing looks new after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_s0    <= '0;
            pc_s1    <= '0;
            instr_s0 <= trace_monitor_pkg::nop_instr;
            instr_s1 <= trace_monitor_pkg::nop_instr;
        end else begin
            pc_s0    <= pc;
            instr_s0 <= instr;
            pc_s1    <= pc_s0;
            instr_s1 <= instr_s0;
        end
    end

    // trigger flags follow the sampled pc, so they flip on the edge that
    // moves the matching pc into stage 1
    // an end match wins when both addresses are equal
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            start_reached <= 1'b0;
            end_reached   <= 1'b0;
        end else if (trig_clr) begin
            start_reached <= 1'b0;
            end_reached   <= 1'b0;
        end else if (end_en && pc_s0 == end_addr) begin
            end_reached   <= 1'b1;
            start_reached <= 1'b0;
        end else if (start_en && pc_s0 == start_addr) begin
            start_reached <= 1'b1;
            end_reached   <= 1'b0;
        end
    end

    // stage 1 is leaving, i.e. stage 0 already holds a different pc
    assign is_new    = (pc_s1 != pc_s0) && (pc_s1 != '0);
    assign trig_ok   = (start_reached || !start_en) && (!end_reached || !end_en);
    // bounds are inclusive
    assign in_window = (!lower_en || pc_s1 >= lower_bound)
                    && (!upper_en || pc_s1 <= upper_bound);

    assign capture   = is_new && en && trig_ok && in_window;
    assign cap_pc    = pc_s1;
    assign cap_instr = instr_s1;

    // the core has to present known values for whatever gets traced
    a_capture_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(capture) && (!capture || !$isunknown({cap_pc, cap_instr}))
    );

endmodule

`default_nettype wire

// ==== design/event_counters.sv ====
/*
 * one saturating counter per performance event input; a capture restarts
 * every counter so each packet carries the events since the previous one
 */
`timescale 1ns/1ps
`default_nettype none

module event_counters (
    input  logic clk,
    input  logic rst_n,
    input  logic [trace_monitor_pkg::num_events-1:0] events,
    input  logic capture,
    output logic [trace_monitor_pkg::num_events-1:0][trace_monitor_pkg::event_cnt_width-1:0]
                 counts
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            counts <= '0;
        end else begin
            for (int i = 0; i < trace_monitor_pkg::num_events; i++) begin
                // pulses in the capture cycle itself are dropped
                if (capture) begin
                    counts[i] <= '0;
                end else if (events[i] && counts[i] != '1) begin
                    counts[i] <= counts[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/trace_packer.sv ====
/*
 * builds the trace packet on each capture: instruction, pc, cycles since
 * the previous capture, and the event counts of that interval
 */
`timescale 1ns/1ps
`default_nettype none

module trace_packer (
    input  logic clk,
    input  logic rst_n,
    input  logic capture,
    input  logic [trace_monitor_pkg::xlen-1:0]        cap_pc,
    input  logic [trace_monitor_pkg::instr_width-1:0] cap_instr,
    input  logic [trace_monitor_pkg::num_events-1:0][trace_monitor_pkg::event_cnt_width-1:0]
                 counts,
    output logic pkt_valid,
    output trace_monitor_pkg::trace_pkt_u pkt
);

    logic [trace_monitor_pkg::delta_width-1:0] cycle_cnt;
    logic [trace_monitor_pkg::delta_width-1:0] last_ts;

    // free-running clock counter and time of the last capture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
            last_ts   <= '0;
            pkt_valid <= 1'b0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
            pkt_valid <= capture;
            if (capture) begin
                last_ts <= cycle_cnt;
            end
        end
    end

    // payload, qualified by pkt_valid
    always_ff @(posedge clk) begin
        if (capture) begin
            pkt.fields.instr  <= cap_instr;
            pkt.fields.pc     <= cap_pc;
            // wraps naturally with the counter
            pkt.fields.delta  <= cycle_cnt - last_ts;
            pkt.fields.counts <= counts;
        end
    end

endmodule

`default_nettype wire

// ==== design/trace_stream_fifo.sv ====
/*
 * circular packet buffer feeding an AXI-stream master; tlast marks every
 * tlast_interval-th beat, packets arriving while full are dropped and flagged
 */
`timescale 1ns/1ps
`default_nettype none

module trace_stream_fifo #(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic pkt_valid,
    input  trace_monitor_pkg::trace_pkt_u pkt,
    output logic m_axis_tvalid,
    input  logic m_axis_tready,
    output logic [trace_monitor_pkg::pkt_width-1:0] m_axis_tdata,
    output logic m_axis_tlast,
    input  logic [trace_monitor_pkg::apb_data_width-1:0] tlast_interval,
    input  logic overflow_clr,
    output logic overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [trace_monitor_pkg::pkt_width-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic [trace_monitor_pkg::apb_data_width-1:0] beat_cnt;
    logic full;
    logic push;
    logic pop;

    assign full = (count == CNT_W'(DEPTH));
    // full is judged before any pop in the same cycle
    assign push = pkt_valid && !full;
    assign pop  = m_axis_tvalid && m_axis_tready;

    assign m_axis_tvalid = (count != '0);
    assign m_axis_tdata  = mem[rd_ptr];
    // interval 0 or 1 marks every beat
    assign m_axis_tlast  = (tlast_interval <= 1) || (beat_cnt >= tlast_interval - 1'b1);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= pkt.raw;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            beat_cnt <= '0;
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr   <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                beat_cnt <= m_axis_tlast ? '0 : beat_cnt + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
            // a drop in the clearing cycle keeps the flag set
            if (pkt_valid && full) begin
                overflow <= 1'b1;
            end else if (overflow_clr) begin
                overflow <= 1'b0;
            end
        end
    end

    a_axis_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (m_axis_tvalid && !m_axis_tready) |=>
            (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast))
    );

endmodule

`default_nettype wire

// ==== design/trace_monitor_top.sv ====
/*
 * trace monitor top level: core trace inputs, APB configuration port and
 * AXI-stream packet output; DEPTH sets the packet FIFO size
 */
`timescale 1ns/1ps
`default_nettype none

module trace_monitor_top #(
    parameter int DEPTH = 4
) (
    input  logic clk,
    input  logic rst_n,
    // core side
    input  logic [trace_monitor_pkg::xlen-1:0]        pc,
    input  logic [trace_monitor_pkg::instr_width-1:0] instr,
    input  logic                                     en,
    input  logic [trace_monitor_pkg::num_events-1:0]  events,
    // APB slave
    input  logic                                         psel,
    input  logic                                         penable,
    input  logic                                         pwrite,
    input  logic [trace_monitor_pkg::apb_addr_width-1:0] paddr,
    input  logic [trace_monitor_pkg::apb_data_width-1:0] pwdata,
    output logic [trace_monitor_pkg::apb_data_width-1:0] prdata,
    output logic                                         pready,
    output logic                                         pslverr,
    // AXI-stream master
    output logic                                   m_axis_tvalid,
    input  logic                                   m_axis_tready,
    output logic [trace_monitor_pkg::pkt_width-1:0] m_axis_tdata,
    output logic                                   m_axis_tlast
);

    logic start_en;
    logic end_en;
    logic lower_en;
    logic upper_en;
    logic [trace_monitor_pkg::xlen-1:0] start_addr;
    logic [trace_monitor_pkg::xlen-1:0] end_addr;
    logic [trace_monitor_pkg::xlen-1:0] lower_bound;
    logic [trace_monitor_pkg::xlen-1:0] upper_bound;
    logic [trace_monitor_pkg::apb_data_width-1:0] tlast_interval;
    logic overflow_clr;
    logic trig_clr;
    logic start_reached;
    logic end_reached;
    logic overflow;
    logic capture;
    logic [trace_monitor_pkg::xlen-1:0]        cap_pc;
    logic [trace_monitor_pkg::instr_width-1:0] cap_instr;
    logic [trace_monitor_pkg::num_events-1:0][trace_monitor_pkg::event_cnt_width-1:0] counts;
    logic pkt_valid;
    trace_monitor_pkg::trace_pkt_u pkt;

    trace_ctrl_regs regs_i (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .start_reached, .end_reached, .overflow,
        .start_en, .end_en, .lower_en, .upper_en,
        .start_addr, .end_addr, .lower_bound, .upper_bound,
        .tlast_interval, .overflow_clr, .trig_clr
    );

    trace_qualifier qual_i (
        .clk, .rst_n, .pc, .instr, .en,
        .start_en, .end_en, .lower_en, .upper_en,
        .start_addr, .end_addr, .lower_bound, .upper_bound, .trig_clr,
        .capture, .cap_pc, .cap_instr, .start_reached, .end_reached
    );

    event_counters evcnt_i (
        .clk, .rst_n, .events, .capture, .counts
    );

    trace_packer packer_i (
        .clk, .rst_n, .capture, .cap_pc, .cap_instr, .counts, .pkt_valid, .pkt
    );

    trace_stream_fifo #(
        .DEPTH(DEPTH)
    ) fifo_i (
        .clk, .rst_n, .pkt_valid, .pkt,
        .m_axis_tvalid, .m_axis_tready, .m_axis_tdata, .m_axis_tlast,
        .tlast_interval, .overflow_clr, .overflow
    );

endmodule

`default_nettype wire

// ==== sim/tb_trace_monitor.sv ====
/*
 * directed testbench for the trace monitor: drives core trace inputs and APB,
 * collects AXI-stream beats in a queue and checks them packet by packet
 */
`timescale 1ns/1ps
`default_nettype none

module tb_trace_monitor;

    localparam int aw         = trace_monitor_pkg::apb_addr_width;
    localparam int dw         = trace_monitor_pkg::apb_data_width;
    localparam int hold_k     = 4;
    // the tests take roughly 700 cycles, the rest is margin
    localparam int max_cycles = 3000;

    logic                                     clk = 1'b0;
    logic                                     rst_n;
    logic [trace_monitor_pkg::xlen-1:0]        pc;
    logic [trace_monitor_pkg::instr_width-1:0] instr;
    logic                                     en;
    logic [trace_monitor_pkg::num_events-1:0]  events;
    logic                                     psel;
    logic                                     penable;
    logic                                     pwrite;
    logic [aw-1:0]                            paddr;
    logic [dw-1:0]                            pwdata;
    logic [dw-1:0]                            prdata;
    logic                                     pready;
    logic                                     pslverr;
    logic                                     m_axis_tvalid;
    logic                                     m_axis_tready;
    logic [trace_monitor_pkg::pkt_width-1:0]  m_axis_tdata;
    logic                                     m_axis_tlast;

    // beats seen on the stream, oldest first
    logic [trace_monitor_pkg::pkt_width-1:0]  beat_q[$];
    logic                                     last_q[$];
    int                                       run_cycles = 0;
    int                                       seed;
    // tlast model: interval in force and beats since the last marked one
    int                                       cur_interval;
    int                                       run_len;

    trace_monitor_top #(
        .DEPTH(4)
    ) dut_i (
        .clk, .rst_n, .pc, .instr, .en, .events,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .m_axis_tvalid, .m_axis_tready, .m_axis_tdata, .m_axis_tlast
    );

    always #5 clk = ~clk;

    // inputs only move on the falling edge, so the rising edge sees settled values
    always @(posedge clk) begin
        if (rst_n && m_axis_tvalid && m_axis_tready) begin
            beat_q.push_back(m_axis_tdata);
            last_q.push_back(m_axis_tlast);
        end
    end

    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles >= max_cycles) begin
            stop_on_error($sformatf("timeout: run went past %0d cycles", max_cycles));
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        stop_on_error($sformatf("Fail at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
    endtask

    // any instruction word will do, it only has to follow the pc
    function automatic logic [31:0] instr_for(input logic [31:0] p);
        return p ^ 32'h0001_0093;
    endfunction

    // one APB access, setup then access phase; response sampled at the ending edge
    task automatic apb_transfer(input logic wr, input logic [aw-1:0] addr,
                                input logic [dw-1:0] wdata, output logic [dw-1:0] rdata,
                                output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        @(posedge clk);
        rdata = prdata;
        err   = pslverr;
        assert (pready) else stop_on_error("pready was low in an access phase");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [aw-1:0] addr, input logic [dw-1:0] data,
                             input logic exp_err);
        logic [dw-1:0] rdata;
        logic          err;
        apb_transfer(1'b1, addr, data, rdata, err);
        assert (err == exp_err) else report_value("pslverr", exp_err, err);
        if (addr == trace_monitor_pkg::reg_tlast_interval && !exp_err) begin
            cur_interval = data;
        end
    endtask

    task automatic apb_read(input logic [aw-1:0] addr, input logic [dw-1:0] exp_data,
                            input logic exp_err);
        logic [dw-1:0] rdata;
        logic          err;
        apb_transfer(1'b0, addr, '0, rdata, err);
        assert (err == exp_err) else report_value("pslverr", exp_err, err);
        if (!exp_err) begin
            assert (rdata == exp_data) else report_value("prdata", exp_data, rdata);
        end
    endtask

    // hold a pc for some cycles; ev_n[j] pulses on events[j] from the third cycle,
    // the first two belong to the previous packet or fall in its capture cycle
    task automatic step_pc(input logic [31:0] new_pc, input logic [31:0] new_instr,
                           input int hold, input logic [3:0][15:0] ev_n);
        for (int i = 0; i < hold; i++) begin
            @(negedge clk);
            pc    = new_pc;
            instr = new_instr;
            for (int j = 0; j < 4; j++) begin
                events[j] = (i >= 2) && (i - 2 < ev_n[j]);
            end
        end
    endtask

    task automatic expect_pkt(input logic [31:0] exp_pc, input logic [31:0] exp_instr,
                              input bit chk_delta, input logic [31:0] exp_delta,
                              input logic [31:0] exp_counts);
        trace_monitor_pkg::trace_pkt_u got;
        logic                          got_last;
        logic                          exp_last;
        int                            waited;
        waited = 0;
        while (beat_q.size() == 0 && waited < 100) begin
            @(negedge clk);
            waited++;
        end
        assert (beat_q.size() != 0)
            else stop_on_error($sformatf("no stream beat arrived for pc %h", exp_pc));
        got.raw  = beat_q.pop_front();
        got_last = last_q.pop_front();
        // every cur_interval-th beat is marked
        exp_last = (cur_interval <= 1) || (run_len + 1 == cur_interval);
        run_len  = exp_last ? 0 : run_len + 1;
        assert (got.fields.pc == exp_pc) else report_value("tdata.pc", exp_pc, got.fields.pc);
        assert (got.fields.instr == exp_instr)
            else report_value("tdata.instr", exp_instr, got.fields.instr);
        if (chk_delta) begin
            assert (got.fields.delta == exp_delta)
                else report_value("tdata.delta", exp_delta, got.fields.delta);
        end
        assert (got.fields.counts == exp_counts)
            else report_value("tdata.counts", exp_counts, got.fields.counts);
        assert (got_last == exp_last) else report_value("m_axis_tlast", exp_last, got_last);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(negedge clk);
        assert (beat_q.size() == 0)
            else report_value("pending stream beats", 0, beat_q.size());
    endtask

    task automatic register_access();
        apb_read(trace_monitor_pkg::reg_ctrl, 32'h0, 1'b0);
        apb_read(trace_monitor_pkg::reg_start_addr, 32'h0, 1'b0);
        apb_read(trace_monitor_pkg::reg_end_addr, 32'h0, 1'b0);
        apb_read(trace_monitor_pkg::reg_lower_bound, 32'h0, 1'b0);
        apb_read(trace_monitor_pkg::reg_upper_bound, 32'hffff_ffff, 1'b0);
        apb_read(trace_monitor_pkg::reg_tlast_interval, 32'h1, 1'b0);
        apb_read(trace_monitor_pkg::reg_status, 32'h0, 1'b0);
        apb_write(trace_monitor_pkg::reg_start_addr, 32'h0000_1000, 1'b0);
        apb_write(trace_monitor_pkg::reg_end_addr, 32'h0000_2000, 1'b0);
        apb_write(trace_monitor_pkg::reg_lower_bound, 32'h0000_0100, 1'b0);
        apb_write(trace_monitor_pkg::reg_upper_bound, 32'h0000_01fc, 1'b0);
        apb_write(trace_monitor_pkg::reg_tlast_interval, 32'd5, 1'b0);
        apb_write(trace_monitor_pkg::reg_ctrl, 32'hf, 1'b0);
        apb_read(trace_monitor_pkg::reg_start_addr, 32'h0000_1000, 1'b0);
        apb_read(trace_monitor_pkg::reg_end_addr, 32'h0000_2000, 1'b0);
        apb_read(trace_monitor_pkg::reg_lower_bound, 32'h0000_0100, 1'b0);
        apb_read(trace_monitor_pkg::reg_upper_bound, 32'h0000_01fc, 1'b0);
        apb_read(trace_monitor_pkg::reg_tlast_interval, 32'd5, 1'b0);
        apb_read(trace_monitor_pkg::reg_ctrl, 32'hf, 1'b0);
        apb_write(trace_monitor_pkg::reg_ctrl, 32'h0, 1'b0);
        apb_write(trace_monitor_pkg::reg_tlast_interval, 32'd1, 1'b0);
        // unmapped offsets answer with an error
        apb_write(8'h1c, 32'hdead_beef, 1'b1);
        apb_read(8'h1c, 32'h0, 1'b1);
        apb_read(8'h80, 32'h0, 1'b1);
        apb_read(trace_monitor_pkg::reg_status, 32'h0, 1'b0);
    endtask

    task automatic basic_trace();
        logic [31:0] pcs[6];
        logic [31:0] instrs[6];
        for (int i = 0; i < 6; i++) begin
            pcs[i] = $random(seed) & 32'hffff_fffc;
            if (pcs[i] == '0 || (i > 0 && pcs[i] == pcs[i-1])) begin
                pcs[i] = pcs[i] + 32'h4;
            end
            instrs[i] = $random(seed);
        end
        for (int i = 0; i < 6; i++) begin
            step_pc(pcs[i], instrs[i], hold_k, '0);
        end
        // a following pc releases the last capture
        step_pc(32'h0, trace_monitor_pkg::nop_instr, hold_k, '0);
        for (int i = 0; i < 6; i++) begin
            expect_pkt(pcs[i], instrs[i], i > 0, hold_k, 32'h0);
        end
        expect_quiet(10);
    endtask

    task automatic window_and_triggers();
        logic [31:0] win_pcs[7];
        logic [31:0] trig_pcs[8];
        win_pcs  = '{32'h080, 32'h100, 32'h150, 32'h1fc, 32'h200, 32'h180, 32'h300};
        trig_pcs = '{32'h300, 32'h380, 32'h400, 32'h420, 32'h440, 32'h500, 32'h520, 32'h540};
        apb_write(trace_monitor_pkg::reg_lower_bound, 32'h100, 1'b0);
        apb_write(trace_monitor_pkg::reg_upper_bound, 32'h1fc, 1'b0);
        apb_write(trace_monitor_pkg::reg_ctrl, 32'hc, 1'b0);
        foreach (win_pcs[i]) begin
            step_pc(win_pcs[i], instr_for(win_pcs[i]), hold_k, '0);
        end
        step_pc(32'h0, trace_monitor_pkg::nop_instr, hold_k, '0);
        // bounds inclusive; 0x200 is skipped so 0x180 comes two holds later
        expect_pkt(32'h100, instr_for(32'h100), 1'b0, 0, 32'h0);
        expect_pkt(32'h150, instr_for(32'h150), 1'b1, hold_k, 32'h0);
        expect_pkt(32'h1fc, instr_for(32'h1fc), 1'b1, hold_k, 32'h0);
        expect_pkt(32'h180, instr_for(32'h180), 1'b1, 2 * hold_k, 32'h0);
        expect_quiet(10);
        apb_write(trace_monitor_pkg::reg_start_addr, 32'h400, 1'b0);
        apb_write(trace_monitor_pkg::reg_end_addr, 32'h500, 1'b0);
        apb_write(trace_monitor_pkg::reg_ctrl, 32'h3, 1'b0);
        foreach (trig_pcs[i]) begin
            step_pc(trig_pcs[i], instr_for(trig_pcs[i]), hold_k, '0);
        end
        step_pc(32'h0, trace_monitor_pkg::nop_instr, hold_k, '0);
        // start address is traced, end address is not
        expect_pkt(32'h400, instr_for(32'h400), 1'b0, 0, 32'h0);
        expect_pkt(32'h420, instr_for(32'h420), 1'b1, hold_k, 32'h0);
        expect_pkt(32'h440, instr_for(32'h440), 1'b1, hold_k, 32'h0);
        expect_quiet(10);
        apb_read(trace_monitor_pkg::reg_status, 32'h4, 1'b0);
        apb_write(trace_monitor_pkg::reg_ctrl, 32'h0, 1'b0);
        apb_read(trace_monitor_pkg::reg_status, 32'h0, 1'b0);
    endtask

    task automatic event_counts();
        step_pc(32'h600, instr_for(32'h600), 8, '0);
        step_pc(32'h640, instr_for(32'h640), 8, {16'd6, 16'd3, 16'd2, 16'd1});
        // 298 and exactly 255 pulses both read as 255
        step_pc(32'h680, instr_for(32'h680), 300, {16'd10, 16'd255, 16'd0, 16'd298});
        step_pc(32'h0, trace_monitor_pkg::nop_instr, hold_k, '0);
        expect_pkt(32'h600, instr_for(32'h600), 1'b0, 0, 32'h0);
        expect_pkt(32'h640, instr_for(32'h640), 1'b1, 8, {8'd6, 8'd3, 8'd2, 8'd1});
        // 0x680 was held for 300 cycles before the next pc released it
        expect_pkt(32'h680, instr_for(32'h680), 1'b1, 300, {8'd10, 8'd255, 8'd0, 8'd255});
        expect_quiet(10);
    endtask

    task automatic backpressure_tlast();
        apb_write(trace_monitor_pkg::reg_tlast_interval, 32'd3, 1'b0);
        @(negedge clk);
        m_axis_tready = 1'b0;
        for (int i = 0; i < 6; i++) begin
            step_pc(32'h800 + 4 * i, instr_for(32'h800 + 4 * i), hold_k, '0);
        end
        step_pc(32'h0, trace_monitor_pkg::nop_instr, hold_k, '0);
        apb_read(trace_monitor_pkg::reg_status, 32'h1, 1'b0);
        @(negedge clk);
        assert (m_axis_tvalid) else report_value("m_axis_tvalid", 1, m_axis_tvalid);
        m_axis_tready = 1'b1;
        // four fit in the FIFO, the last two were dropped
        for (int i = 0; i < 4; i++) begin
            expect_pkt(32'h800 + 4 * i, instr_for(32'h800 + 4 * i), i > 0, hold_k, 32'h0);
        end
        expect_quiet(10);
        apb_write(trace_monitor_pkg::reg_status, 32'h1, 1'b0);
        apb_read(trace_monitor_pkg::reg_status, 32'h0, 1'b0);
        step_pc(32'h900, instr_for(32'h900), hold_k, '0);
        step_pc(32'h904, instr_for(32'h904), hold_k, '0);
        step_pc(32'h0, trace_monitor_pkg::nop_instr, hold_k, '0);
        expect_pkt(32'h900, instr_for(32'h900), 1'b0, 0, 32'h0);
        expect_pkt(32'h904, instr_for(32'h904), 1'b1, hold_k, 32'h0);
        expect_quiet(10);
    endtask

    initial begin
        rst_n         = 1'b0;
        pc            = '0;
        instr         = trace_monitor_pkg::nop_instr;
        en            = 1'b0;
        events        = '0;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        m_axis_tready = 1'b0;
        seed          = 32'hf63fc41d;
        cur_interval  = 1;
        run_len       = 0;
        repeat (2) @(negedge clk);
        rst_n         = 1'b1;
        en            = 1'b1;
        m_axis_tready = 1'b1;
        register_access();
        basic_trace();
        window_and_triggers();
        event_counts();
        backpressure_tlast();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== trace_monitor.f ====
design/trace_monitor_pkg.sv
design/trace_ctrl_regs.sv
design/trace_qualifier.sv
design/event_counters.sv
design/trace_packer.sv
design/trace_stream_fifo.sv
design/trace_monitor_top.sv
sim/tb_trace_monitor.sv
